// ==== design/vga_pkg.sv ====
package vga_pkg;

    // ==============================
    // Display types
    // ==============================

    // Beam or sprite position
    typedef logic [9:0] coord_t;

    // 4 bits per channel, red in the top nibble
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Both syncs pulse low
    localparam logic SYNC_ACTIVE = 1'b0;

    // ==============================
    // Palette
    // ==============================
    localparam rgb_t RGB_BLACK    = rgb_t'(12'h000);
    localparam rgb_t RGB_SKY      = rgb_t'(12'h5AF);
    localparam rgb_t RGB_GROUND_A = rgb_t'(12'h840);
    localparam rgb_t RGB_GROUND_B = rgb_t'(12'hA60);
    localparam rgb_t RGB_RED      = rgb_t'(12'hF00);
    localparam rgb_t RGB_BLUE     = rgb_t'(12'h00F);
    localparam rgb_t RGB_COIN     = rgb_t'(12'hFF0);

endpackage

// ==== design/game_pkg.sv ====
package game_pkg;

    // ==============================
    // Keyboard
    // ==============================

    // HID usage code of the pressed key
    typedef logic [7:0] keycode_t;

    localparam keycode_t KEY_LEFT  = 8'h04;  // A
    localparam keycode_t KEY_RIGHT = 8'h07;  // D
    localparam keycode_t KEY_JUMP  = 8'h1A;  // W

    // ==============================
    // Sprite sizes and physics
    // ==============================
    localparam logic [9:0] PLAYER_W       = 10'd16;
    localparam logic [9:0] PLAYER_H       = 10'd16;
    localparam logic [9:0] COIN_W         = 10'd8;
    localparam logic [9:0] COIN_H         = 10'd14;
    localparam logic [9:0] GROUND_H       = 10'd16;

    // Per-frame steps
    localparam logic [9:0] STEP_X         = 10'd2;
    localparam logic [9:0] JUMP_V         = 10'd8;
    localparam logic [9:0] GRAVITY        = 10'd1;
    localparam logic [9:0] PLAYER_START_X = 10'd16;

    // Negative means moving up the screen
    typedef logic signed [5:0] vel_t;

    // Coins collected so far, six hex digits
    typedef logic [23:0] score_t;

    // Active low segments, decimal point in bit 7
    typedef logic [7:0] seg_t;

endpackage

// ==== design/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  logic   Clk,
    input  logic   arst_n,
    output logic   pix_tick,
    output coord_t draw_x,
    output coord_t draw_y,
    output logic   hs_raw,
    output logic   vs_raw,
    output logic   blank,
    output logic   frame_start
);

    localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    // Sync windows
    localparam coord_t HS_START = coord_t'(H_VISIBLE + H_FRONT);
    localparam coord_t HS_END   = coord_t'(H_VISIBLE + H_FRONT + H_SYNC);
    localparam coord_t VS_START = coord_t'(V_VISIBLE + V_FRONT);
    localparam coord_t VS_END   = coord_t'(V_VISIBLE + V_FRONT + V_SYNC);
    localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);
    localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);

    coord_t h_next;
    coord_t v_next;

    // Wrap at the totals, vertical steps at end of line
    always_comb begin
        h_next = (draw_x == H_LAST) ? '0 : draw_x + 10'd1;
        v_next = draw_y;
        if (draw_x == H_LAST) begin
            v_next = (draw_y == V_LAST) ? '0 : draw_y + 10'd1;
        end
    end

    // Counters start on the last pixel so the first tick lands on (0, 0)
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            pix_tick    <= 1'b1;
            draw_x      <= H_LAST;
            draw_y      <= V_LAST;
            frame_start <= 1'b0;
        end else begin
            pix_tick    <= ~pix_tick;
            frame_start <= pix_tick && (h_next == '0) && (v_next == VS_START);
            if (pix_tick) begin
                draw_x <= h_next;
                draw_y <= v_next;
            end
        end
    end

    // Raw syncs and blanking straight from the beam
    assign hs_raw = (draw_x >= HS_START && draw_x < HS_END) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
    assign vs_raw = (draw_y >= VS_START && draw_y < VS_END) ? SYNC_ACTIVE : ~SYNC_ACTIVE;
    assign blank  = (draw_x >= coord_t'(H_VISIBLE)) || (draw_y >= coord_t'(V_VISIBLE));

    a_beam_in_frame: assert property (@(posedge Clk) disable iff (!arst_n)
        (draw_x < coord_t'(H_TOTAL)) && (draw_y < coord_t'(V_TOTAL)));

    // One game step per frame
    a_frame_pulse: assert property (@(posedge Clk) disable iff (!arst_n)
        frame_start |=> !frame_start);

endmodule

// ==== design/player_motion.sv ====
`timescale 1ns/1ps

module player_motion
    import vga_pkg::*;
    import game_pkg::*;
#(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  logic     Clk,
    input  logic     arst_n,
    input  logic     frame_start,
    input  keycode_t keycode,
    output coord_t   player_x,
    output coord_t   player_y,
    output logic     player_update
);

    // Right edge clamp and standing height
    localparam coord_t X_MAX   = coord_t'(H_VISIBLE) - PLAYER_W;
    localparam coord_t FLOOR_Y = coord_t'(V_VISIBLE) - GROUND_H - PLAYER_H;

    vel_t               vel;
    logic               in_air;
    coord_t             x_right;
    logic signed [11:0] y_sum;

    // Candidate positions before clamping
    always_comb begin
        x_right = player_x + STEP_X;
        y_sum   = $signed({2'b00, player_y}) + $signed({{6{vel[5]}}, vel});
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            player_x      <= PLAYER_START_X;
            player_y      <= FLOOR_Y;
            vel           <= '0;
            in_air        <= 1'b0;
            player_update <= 1'b0;
        end else begin
            player_update <= frame_start;
            if (frame_start) begin
                // Walk, clamped to the visible width
                if (keycode == KEY_RIGHT) begin
                    player_x <= (x_right > X_MAX) ? X_MAX : x_right;
                end else if (keycode == KEY_LEFT) begin
                    player_x <= (player_x < STEP_X) ? '0 : player_x - STEP_X;
                end

                if (!in_air) begin
                    // Take-off frame only loads the velocity
                    if (keycode == KEY_JUMP) begin
                        vel    <= -vel_t'(JUMP_V);
                        in_air <= 1'b1;
                    end
                end else if (y_sum >= $signed({2'b00, FLOOR_Y})) begin
                    // Landed on the ground strip
                    player_y <= FLOOR_Y;
                    vel      <= '0;
                    in_air   <= 1'b0;
                end else begin
                    // Move first, then gravity
                    player_y <= coord_t'(y_sum);
                    vel      <= vel + vel_t'(GRAVITY);
                end
            end
        end
    end

    a_x_clamped: assert property (@(posedge Clk) disable iff (!arst_n)
        player_x <= X_MAX);

endmodule

// ==== design/coin_unit.sv ====
`timescale 1ns/1ps

module coin_unit
    import vga_pkg::*;
    import game_pkg::*;
#(
    parameter int COIN_X = 200,
    parameter int COIN_Y = 450
) (
    input  logic   Clk,
    input  logic   arst_n,
    input  logic   player_update,
    input  coord_t player_x,
    input  coord_t player_y,
    input  coord_t draw_x,
    input  coord_t draw_y,
    output logic   collected,
    output logic   coin_px
);

    localparam coord_t CX = coord_t'(COIN_X);
    localparam coord_t CY = coord_t'(COIN_Y);

    logic present;
    logic touch;

    // Box overlap, player against coin
    always_comb begin
        touch = (player_x < CX + COIN_W) && (player_x + PLAYER_W > CX)
             && (player_y < CY + COIN_H) && (player_y + PLAYER_H > CY);
    end

    // Beam inside the coin box
    assign coin_px = present
                  && (draw_x >= CX) && (draw_x < CX + COIN_W)
                  && (draw_y >= CY) && (draw_y < CY + COIN_H);

    // Tested once the new player position is settled
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            present   <= 1'b1;
            collected <= 1'b0;
        end else begin
            collected <= 1'b0;
            if (player_update && present && touch) begin
                collected <= 1'b1;
                present   <= 1'b0;
            end
        end
    end

    // Single count per coin
    a_collect_once: assert property (@(posedge Clk) disable iff (!arst_n)
        collected |-> $past(present));

endmodule

// ==== design/score_display.sv ====
`timescale 1ns/1ps

module score_display
    import game_pkg::*;
(
    input  logic Clk,
    input  logic arst_n,
    input  logic collected0,
    input  logic collected1,
    output seg_t hex0,
    output seg_t hex1,
    output seg_t hex2,
    output seg_t hex3,
    output seg_t hex4,
    output seg_t hex5
);

    score_t score;

    // Hex digit to active-low segments, DP dark
    function automatic seg_t hex_seg(input logic [3:0] nib);
        case (nib)
            4'h0: hex_seg = 8'hC0;
            4'h1: hex_seg = 8'hF9;
            4'h2: hex_seg = 8'hA4;
            4'h3: hex_seg = 8'hB0;
            4'h4: hex_seg = 8'h99;
            4'h5: hex_seg = 8'h92;
            4'h6: hex_seg = 8'h82;
            4'h7: hex_seg = 8'hF8;
            4'h8: hex_seg = 8'h80;
            4'h9: hex_seg = 8'h90;
            4'hA: hex_seg = 8'h88;
            4'hB: hex_seg = 8'h83;
            4'hC: hex_seg = 8'hC6;
            4'hD: hex_seg = 8'hA1;
            4'hE: hex_seg = 8'h86;
            4'hF: hex_seg = 8'h8E;
        endcase
    endfunction

    // Both coins may go in the same cycle
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            score <= '0;
        end else begin
            score <= score + score_t'(collected0) + score_t'(collected1);
        end
    end

    // Lowest nibble on hex0
    assign hex0 = hex_seg(score[3:0]);
    assign hex1 = hex_seg(score[7:4]);
    assign hex2 = hex_seg(score[11:8]);
    assign hex3 = hex_seg(score[15:12]);
    assign hex4 = hex_seg(score[19:16]);
    assign hex5 = hex_seg(score[23:20]);

endmodule

// ==== design/color_mapper.sv ====
`timescale 1ns/1ps

module color_mapper
    import vga_pkg::*;
    import game_pkg::*;
#(
    parameter int V_VISIBLE = 480
) (
    input  logic   Clk,
    input  logic   arst_n,
    input  logic   pix_tick,
    input  coord_t draw_x,
    input  coord_t draw_y,
    input  logic   blank,
    input  logic   hs_raw,
    input  logic   vs_raw,
    input  coord_t player_x,
    input  coord_t player_y,
    input  logic   coin0_px,
    input  logic   coin1_px,
    output rgb_t   rgb,
    output logic   hs,
    output logic   vs
);

    localparam coord_t GROUND_TOP = coord_t'(V_VISIBLE) - GROUND_H;

    logic player_hit;
    logic player_top;
    rgb_t pix_color;

    // ==============================
    // Layering, top priority first
    // ==============================
    always_comb begin
        player_hit = (draw_x >= player_x) && (draw_x < player_x + PLAYER_W)
                  && (draw_y >= player_y) && (draw_y < player_y + PLAYER_H);
        // Red cap over blue overalls
        player_top = draw_y < player_y + (PLAYER_H >> 1);

        if (blank) begin
            pix_color = RGB_BLACK;
        end else if (player_hit) begin
            pix_color = player_top ? RGB_RED : RGB_BLUE;
        end else if (coin0_px || coin1_px) begin
            pix_color = RGB_COIN;
        end else if (draw_y >= GROUND_TOP) begin
            // 8x8 brick checker
            pix_color = (draw_x[3] ^ draw_y[3]) ? RGB_GROUND_B : RGB_GROUND_A;
        end else begin
            pix_color = RGB_SKY;
        end
    end

    // Colour and syncs leave together
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            rgb <= RGB_BLACK;
            hs  <= ~SYNC_ACTIVE;
            vs  <= ~SYNC_ACTIVE;
        end else if (pix_tick) begin
            rgb <= pix_color;
            hs  <= hs_raw;
            vs  <= vs_raw;
        end
    end

endmodule

// ==== design/mario_top.sv ====
`timescale 1ns/1ps

module mario_top
    import vga_pkg::*;
    import game_pkg::*;
#(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33,
    parameter int COIN0_X   = 200,
    parameter int COIN0_Y   = 450,
    parameter int COIN1_X   = 400,
    parameter int COIN1_Y   = 450
) (
    input  logic     Clk,
    input  logic     arst_n,
    input  keycode_t keycode,
    output rgb_t     rgb,
    output logic     hs,
    output logic     vs,
    output seg_t     hex0,
    output seg_t     hex1,
    output seg_t     hex2,
    output seg_t     hex3,
    output seg_t     hex4,
    output seg_t     hex5
);

    // ==============================
    // Beam and game state
    // ==============================
    logic   pix_tick;
    logic   hs_raw;
    logic   vs_raw;
    logic   blank;
    logic   frame_start;
    coord_t draw_x;
    coord_t draw_y;
    coord_t player_x;
    coord_t player_y;
    logic   player_update;
    logic   collected0;
    logic   collected1;
    logic   coin0_px;
    logic   coin1_px;

    vga_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) u_vga_timing (
        .Clk         (Clk),
        .arst_n      (arst_n),
        .pix_tick    (pix_tick),
        .draw_x      (draw_x),
        .draw_y      (draw_y),
        .hs_raw      (hs_raw),
        .vs_raw      (vs_raw),
        .blank       (blank),
        .frame_start (frame_start)
    );

    // Moves once per frame, during vertical sync
    player_motion #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) u_player_motion (
        .Clk           (Clk),
        .arst_n        (arst_n),
        .frame_start   (frame_start),
        .keycode       (keycode),
        .player_x      (player_x),
        .player_y      (player_y),
        .player_update (player_update)
    );

    coin_unit #(
        .COIN_X (COIN0_X),
        .COIN_Y (COIN0_Y)
    ) u_coin0 (
        .Clk           (Clk),
        .arst_n        (arst_n),
        .player_update (player_update),
        .player_x      (player_x),
        .player_y      (player_y),
        .draw_x        (draw_x),
        .draw_y        (draw_y),
        .collected     (collected0),
        .coin_px       (coin0_px)
    );

    coin_unit #(
        .COIN_X (COIN1_X),
        .COIN_Y (COIN1_Y)
    ) u_coin1 (
        .Clk           (Clk),
        .arst_n        (arst_n),
        .player_update (player_update),
        .player_x      (player_x),
        .player_y      (player_y),
        .draw_x        (draw_x),
        .draw_y        (draw_y),
        .collected     (collected1),
        .coin_px       (coin1_px)
    );

    score_display u_score_display (
        .Clk        (Clk),
        .arst_n     (arst_n),
        .collected0 (collected0),
        .collected1 (collected1),
        .hex0       (hex0),
        .hex1       (hex1),
        .hex2       (hex2),
        .hex3       (hex3),
        .hex4       (hex4),
        .hex5       (hex5)
    );

    // Final pixel stage
    color_mapper #(
        .V_VISIBLE (V_VISIBLE)
    ) u_color_mapper (
        .Clk      (Clk),
        .arst_n   (arst_n),
        .pix_tick (pix_tick),
        .draw_x   (draw_x),
        .draw_y   (draw_y),
        .blank    (blank),
        .hs_raw   (hs_raw),
        .vs_raw   (vs_raw),
        .player_x (player_x),
        .player_y (player_y),
        .coin0_px (coin0_px),
        .coin1_px (coin1_px),
        .rgb      (rgb),
        .hs       (hs),
        .vs       (vs)
    );

endmodule

// ==== bench/tb_mario_top.sv ====
`timescale 1ns/1ps

module tb_mario_top
    import vga_pkg::*;
    import game_pkg::*;
();

    // ==============================
    // Reduced display timing
    // ==============================
    localparam int H_VISIBLE  = 160;
    localparam int H_FRONT    = 4;
    localparam int H_SYNC     = 8;
    localparam int H_BACK     = 4;
    localparam int V_VISIBLE  = 120;
    localparam int V_FRONT    = 2;
    localparam int V_SYNC     = 2;
    localparam int V_BACK     = 4;
    localparam int H_TOTAL    = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL    = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    // Pixel ticks per frame
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int CLK_PERIOD = 4;

    logic     clk;
    logic     arst_n;
    keycode_t keycode;
    rgb_t     rgb;
    logic     hs;
    logic     vs;
    seg_t     hex0;
    seg_t     hex1;
    seg_t     hex2;
    seg_t     hex3;
    seg_t     hex4;
    seg_t     hex5;

    // Clock edges counted from 0 at the first edge after reset
    int edges = -1;
    int vs_periods;
    bit stim_loaded;

    // One entry per stimulus line
    keycode_t keys [$];
    score_t   scores [$];
    int       probe_x [$];
    int       probe_y [$];
    rgb_t     colors [$];

    mario_top #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK),
        .COIN0_X   (40),
        .COIN0_Y   (90),
        .COIN1_X   (100),
        .COIN1_Y   (90)
    ) dut (
        .Clk     (clk),
        .arst_n  (arst_n),
        .keycode (keycode),
        .rgb     (rgb),
        .hs      (hs),
        .vs      (vs),
        .hex0    (hex0),
        .hex1    (hex1),
        .hex2    (hex2),
        .hex3    (hex3),
        .hex4    (hex4),
        .hex5    (hex5)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            edges <= -1;
        end else begin
            edges <= edges + 1;
        end
    end

    // ==============================
    // Compare helpers
    // ==============================
    task automatic fail_stop();
        $display("Test failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_rgb(input string name, input rgb_t actual, input rgb_t expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %03h, expected %03h", $time, name, actual, expected);
            fail_stop();
        end
    endtask

    task automatic check_seg(input string name, input seg_t actual, input seg_t expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %02h, expected %02h", $time, name, actual, expected);
            fail_stop();
        end
    endtask

    task automatic check_sync(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("[FAIL] t=%0t %s: got %b, expected %b", $time, name, actual, expected);
            fail_stop();
        end
    endtask

    // Clock counts between sync edges
    task automatic check_interval(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("[FAIL] t=%0t %s: got %0d, expected %0d", $time, name, actual, expected);
            fail_stop();
        end
    endtask

    // Lit segments in gfedcba order
    function automatic seg_t seg_pattern(input logic [3:0] digit);
        logic [6:0] lit;
        case (digit)
            4'h0: lit = 7'h3F;
            4'h1: lit = 7'h06;
            4'h2: lit = 7'h5B;
            4'h3: lit = 7'h4F;
            4'h4: lit = 7'h66;
            4'h5: lit = 7'h6D;
            4'h6: lit = 7'h7D;
            4'h7: lit = 7'h07;
            4'h8: lit = 7'h7F;
            4'h9: lit = 7'h6F;
            4'hA: lit = 7'h77;
            4'hB: lit = 7'h7C;
            4'hC: lit = 7'h39;
            4'hD: lit = 7'h5E;
            4'hE: lit = 7'h79;
            4'hF: lit = 7'h71;
        endcase
        // Inverted for the active-low pins with DP dark
        return {1'b1, ~lit};
    endfunction

    // Low inside the sync window
    function automatic logic sync_level(input int pos, input int start, input int len);
        return (pos >= start && pos < start + len) ? 1'b0 : 1'b1;
    endfunction

    task automatic check_score(input score_t expected);
        check_seg("hex0", hex0, seg_pattern(expected[3:0]));
        check_seg("hex1", hex1, seg_pattern(expected[7:4]));
        check_seg("hex2", hex2, seg_pattern(expected[11:8]));
        check_seg("hex3", hex3, seg_pattern(expected[15:12]));
        check_seg("hex4", hex4, seg_pattern(expected[19:16]));
        check_seg("hex5", hex5, seg_pattern(expected[23:20]));
    endtask

    // Pixel k is on the outputs for edges 2k+2 and 2k+3
    task automatic wait_pixel(input int k);
        if (edges > 2 * k + 3) begin
            $display("probe pixel %0d was already past when the check began", k);
            fail_stop();
        end
        while (edges < 2 * k + 2) begin
            @(negedge clk);
        end
    endtask

    task automatic load_stim();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  key_v;
        logic [23:0] score_v;
        logic [11:0] rgb_v;
        int          x_v;
        int          y_v;
        fd = $fopen("bench/mario_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open bench/mario_stim.txt");
            fail_stop();
        end
        while ($fgets(line, fd) > 0) begin
            // Column notes
            if (line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %d %d %h", key_v, score_v, x_v, y_v, rgb_v);
            if (fields == 5) begin
                keys.push_back(key_v);
                scores.push_back(score_v);
                probe_x.push_back(x_v);
                probe_y.push_back(y_v);
                colors.push_back(rgb_t'(rgb_v));
            end
        end
        $fclose(fd);
        if (keys.size() == 0) begin
            $display("the stimulus file holds no usable lines");
            fail_stop();
        end
        stim_loaded = 1'b1;
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        int k;
        arst_n      = 1'b0;
        keycode     = '0;
        vs_periods  = 0;
        stim_loaded = 1'b0;
        load_stim();

        // Reset held for 10 cycles and released on a falling edge
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_rgb("rgb", rgb, RGB_BLACK);
        check_sync("hs", hs, 1'b1);
        check_sync("vs", vs, 1'b1);
        check_score(score_t'(0));
        arst_n = 1'b1;

        for (int i = 0; i < keys.size(); i++) begin
            // Key is taken at this frame's vsync
            keycode = keys[i];
            // New state shows up in the next frame's picture
            k = (i + 1) * FRAME + probe_y[i] * H_TOTAL + probe_x[i];
            wait_pixel(k);
            check_rgb($sformatf("rgb at (%0d,%0d)", probe_x[i], probe_y[i]), rgb, colors[i]);
            check_sync("hs", hs, sync_level(probe_x[i], H_VISIBLE + H_FRONT, H_SYNC));
            check_sync("vs", vs, sync_level(probe_y[i], V_VISIBLE + V_FRONT, V_SYNC));
            check_score(scores[i]);
        end

        if (vs_periods == 0) begin
            $display("no full vertical sync period was measured");
            fail_stop();
        end
        $display("Test completed successfully");
        $finish;
    end

    // Sync widths and spacing sampled mid-cycle
    initial begin : sync_monitor
        logic hs_prev;
        logic vs_prev;
        int   hs_fall;
        int   vs_fall;
        hs_prev = 1'b1;
        vs_prev = 1'b1;
        hs_fall = -1;
        vs_fall = -1;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (hs_prev && !hs) begin
                if (hs_fall >= 0) begin
                    check_interval("hs period", edges - hs_fall, 2 * H_TOTAL);
                end
                hs_fall = edges;
            end
            if (!hs_prev && hs && hs_fall >= 0) begin
                check_interval("hs low width", edges - hs_fall, 2 * H_SYNC);
            end
            if (vs_prev && !vs) begin
                if (vs_fall >= 0) begin
                    check_interval("vs period", edges - vs_fall, 2 * FRAME);
                    vs_periods++;
                end
                vs_fall = edges;
            end
            if (!vs_prev && vs && vs_fall >= 0) begin
                check_interval("vs low width", edges - vs_fall, 2 * H_TOTAL * V_SYNC);
            end
            hs_prev = hs;
            vs_prev = vs;
        end
    end

    initial begin : watchdog
        longint limit;
        wait (stim_loaded);
        // Lines plus two spare frames with half again on top
        limit = longint'(keys.size() + 2) * 2 * FRAME * CLK_PERIOD * 3 / 2;
        #(limit);
        $display("watchdog expired after %0d ns before the last line was checked", limit);
        fail_stop();
    end

endmodule

// ==== bench/mario_stim.txt ====
# key score probe_x probe_y rgb   (key, score and rgb in hex, probe in decimal)
# key is held for one frame, score and probe pixel are checked in the frame after it
07 0 20 90 F00
07 0 44 95 FF0
07 0 30 100 00F
07 0 0 104 A60
07 1 45 92 5AF
07 1 43 96 00F
04 1 44 99 5AF
1A 1 26 88 F00
00 1 26 80 F00
00 1 30 88 00F
00 1 30 88 5AF
00 1 41 62 F00
00 1 26 73 00F
00 1 26 54 5AF
00 1 26 53 F00
00 1 26 52 F00
00 1 26 67 00F
00 1 26 52 5AF
00 1 26 70 00F
00 1 26 57 5AF
00 1 26 62 F00
00 1 26 66 5AF
00 1 26 88 00F
00 1 26 79 5AF
00 1 26 103 00F
07 1 0 112 840
07 1 104 95 FF0
07 1 8 104 840
07 1 34 88 F00
07 1 51 103 00F
07 1 165 10 000
07 1 8 112 A60
07 1 100 90 FF0
07 1 60 115 A60
07 1 61 96 00F
07 1 159 108 840
07 1 50 89 F00
07 1 107 103 FF0
07 1 150 119 840
07 1 71 100 00F
07 1 58 95 F00
07 1 10 5 5AF
07 1 62 119 A60
07 1 79 104 840
07 1 66 100 00F
07 1 120 60 5AF
07 1 85 88 F00
07 1 103 92 FF0
07 1 74 103 00F
07 1 159 0 5AF
07 1 0 119 840
07 1 95 90 F00
07 1 100 100 FF0
07 1 99 99 00F
07 2 104 95 5AF

// ==== all.f ====
design/vga_pkg.sv
design/game_pkg.sv
design/vga_timing.sv
design/player_motion.sv
design/coin_unit.sv
design/score_display.sv
design/color_mapper.sv
design/mario_top.sv
bench/tb_mario_top.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_mario_top -f all.f

./obj_dir/Vtb_mario_top | tee sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
